// ==== project.f ====
source/lab_pkg.sv
source/switch_capture.sv
source/alu4.sv
source/barrel_shifter.sv
source/prio_encoder.sv
source/lfsr8.sv
source/display_driver.sv
source/lab_board_top.sv
verif/lab_board_tb.sv

// ==== Bender.yml ====
package:
  name: lab_board

sources:
  - source/lab_pkg.sv
  - source/switch_capture.sv
  - source/alu4.sv
  - source/barrel_shifter.sv
  - source/prio_encoder.sv
  - source/lfsr8.sv
  - source/display_driver.sv
  - source/lab_board_top.sv
  - target: simulation
    files:
      - verif/lab_board_tb.sv

// ==== verif/lab_board_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_board_tb;

    localparam int RESET_CYCLES = 8;
    localparam int PERIOD_NS    = 10;

    logic          btn;
    logic          rst;
    logic [15:0]   sw;
    logic [1:0]    exp_sel;
    logic [15:0]   ledr;
    lab_pkg::seg_t seg0;
    lab_pkg::seg_t seg1;

    // One vector table entry per row.
    lab_pkg::exp_sel_e tab_sel[$];
    logic [15:0]       tab_sw[$];
    int                tab_hold[$];
    string             tab_name[$];
    logic              table_ready;

    // Reference model state.
    logic [15:0]       cap_sw;
    lab_pkg::exp_sel_e cap_sel;
    logic [7:0]        model_lfsr;
    logic [15:0]       exp_ledr;
    lab_pkg::seg_t     exp_seg0;
    lab_pkg::seg_t     exp_seg1;

    int row_errors;
    int total_errors;
    int rows_passed;
    int rows_failed;

    lab_board_top i_lab_board_top (
        .btn     (btn),
        .rst     (rst),
        .sw      (sw),
        .exp_sel (exp_sel),
        .ledr    (ledr),
        .seg0    (seg0),
        .seg1    (seg1)
    );

    always #(PERIOD_NS / 2) btn = ~btn;

    function automatic logic [15:0] alu_switches(
        input logic [2:0] op,
        input logic [3:0] a,
        input logic [3:0] b
    );
        return {5'd0, op, b, a};
    endfunction

    function automatic logic [15:0] shift_switches(
        input logic [7:0] din,
        input logic [2:0] n,
        input logic       left,
        input logic       arith
    );
        return {n, left, arith, 3'd0, din};
    endfunction

    function automatic logic [15:0] encoder_switches(input logic [7:0] src, input logic en);
        return {7'd0, en, src};
    endfunction

    function automatic void alu_model(
        input  logic [2:0] op,
        input  logic [3:0] a,
        input  logic [3:0] b,
        output logic [3:0] res,
        output logic       zf,
        output logic       vf,
        output logic       cf
    );
        int ua;
        int ub;
        int sa;
        int sb;
        int full;
        int sres;
        ua   = a;
        ub   = b;
        sa   = a[3] ? ua - 16 : ua; // Signed view of the operands.
        sb   = b[3] ? ub - 16 : ub;
        full = 0;
        sres = 0;
        res  = 4'd0;
        vf   = 1'b0;
        cf   = 1'b0;
        case (op)
            lab_pkg::ALU_ADD: begin
                full = ua + ub;
                sres = sa + sb;
            end
            lab_pkg::ALU_SUB: begin
                full = ua + (15 - ub) + 1;
                sres = sa - sb;
            end
            lab_pkg::ALU_NOT:   res = ~a;
            lab_pkg::ALU_AND:   res = a & b;
            lab_pkg::ALU_OR:    res = a | b;
            lab_pkg::ALU_XOR:   res = a ^ b;
            lab_pkg::ALU_LESS:  res = (sa < sb) ? 4'd1 : 4'd0;
            lab_pkg::ALU_EQUAL: res = (ua == ub) ? 4'd1 : 4'd0;
            default:            res = 4'd0;
        endcase
        if (op == lab_pkg::ALU_ADD || op == lab_pkg::ALU_SUB) begin
            res = full[3:0];
            cf  = (full > 15);
            vf  = (sres > 7) || (sres < -8); // Outside the 4-bit signed range.
        end
        zf = (res == 4'd0);
    endfunction

    function automatic logic [7:0] shift_model(
        input logic [7:0] din,
        input logic [2:0] n,
        input logic       left,
        input logic       arith
    );
        logic signed [7:0] sdin;
        logic [7:0]        dout;
        sdin = din;
        if (left) begin
            dout = din << n;
        end else if (arith) begin
            dout = sdin >>> n;
        end else begin
            dout = din >> n;
        end
        return dout;
    endfunction

    function automatic void enc_model(
        input  logic [7:0] src,
        input  logic       en,
        output logic [2:0] idx,
        output logic       any
    );
        idx = 3'd0;
        any = 1'b0;
        if (en) begin
            for (int i = 7; i >= 0; i--) begin
                if (src[i] && !any) begin
                    idx = i[2:0];
                    any = 1'b1;
                end
            end
        end
    endfunction

    // Advances the model by one button edge.
    task automatic model_step();
        logic [3:0] res;
        logic       zf;
        logic       vf;
        logic       cf;
        logic [7:0] sh;
        logic [2:0] idx;
        logic       any;
        alu_model(cap_sw[10:8], cap_sw[3:0], cap_sw[7:4], res, zf, vf, cf);
        sh = shift_model(cap_sw[7:0], cap_sw[15:13], cap_sw[12], cap_sw[11]);
        enc_model(cap_sw[7:0], cap_sw[8], idx, any);
        exp_ledr = '0;
        exp_seg0 = lab_pkg::SEG_BLANK;
        exp_seg1 = lab_pkg::SEG_BLANK;
        case (cap_sel)
            lab_pkg::EXP_ALU: begin
                exp_ledr[6:0] = {cf, vf, zf, res};
                exp_seg0      = lab_pkg::SEG_HEX[res];
                if (res[3]) begin
                    exp_seg1 = lab_pkg::SEG_MINUS;
                end
            end
            lab_pkg::EXP_SHIFT: begin
                exp_ledr[7:0] = sh;
                exp_seg0      = lab_pkg::SEG_HEX[sh[3:0]];
                exp_seg1      = lab_pkg::SEG_HEX[sh[7:4]];
            end
            lab_pkg::EXP_ENCODE: begin
                exp_ledr[2:0] = idx;
                exp_ledr[4]   = any;
                if (any) begin
                    exp_seg0 = lab_pkg::SEG_HEX[idx];
                end
            end
            default: begin
                exp_ledr[7:0] = model_lfsr;
                exp_seg0      = lab_pkg::SEG_HEX[model_lfsr[3:0]];
                exp_seg1      = lab_pkg::SEG_HEX[model_lfsr[7:4]];
            end
        endcase
        // Taps 4, 3, 2 and 0 feed the new bit 7.
        if (model_lfsr == 8'h00) begin
            model_lfsr = lab_pkg::LFSR_SEED;
        end else if (cap_sel == lab_pkg::EXP_RANDOM) begin
            model_lfsr = {^(model_lfsr & 8'h1d), model_lfsr[7:1]};
        end
        cap_sw  = sw;
        cap_sel = lab_pkg::exp_sel_e'(exp_sel);
    endtask

    task automatic check_ledr(input logic [15:0] got, input logic [15:0] want, input string what);
        if (got !== want) begin
            $display("ERR @%0t: %s ledr is %h, expected %h", $time, what, got, want);
            row_errors++;
            total_errors++;
        end
    endtask

    task automatic check_seg(
        input lab_pkg::seg_t got,
        input lab_pkg::seg_t want,
        input string         what
    );
        if (got !== want) begin
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, want);
            row_errors++;
            total_errors++;
        end
    endtask

    task automatic check_outputs(input string name);
        check_ledr(ledr, exp_ledr, name);
        check_seg(seg0, exp_seg0, {name, " seg0"});
        check_seg(seg1, exp_seg1, {name, " seg1"});
    endtask

    task automatic finish_row(input string name);
        if (row_errors == 0) begin
            rows_passed++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            rows_failed++;
            $display("[%0t] %s: %0d mismatches", $time, name, row_errors);
        end
    endtask

    task automatic add_row(
        input lab_pkg::exp_sel_e sel,
        input logic [15:0]       swv,
        input int                hold,
        input string             name
    );
        tab_sel.push_back(sel);
        tab_sw.push_back(swv);
        tab_hold.push_back(hold);
        tab_name.push_back(name);
    endtask

    task automatic build_table();
        logic [7:0] din;
        add_row(lab_pkg::EXP_RANDOM, 16'h0000, 20, "random from seed");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_ADD, 4'd7, 4'd1), 3, "alu 7+1");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_SUB, 4'd8, 4'd1), 3, "alu 8-1");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_ADD, 4'hf, 4'd1), 3, "alu 15+1");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_SUB, 4'd3, 4'd5), 3, "alu 3-5");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_NOT, 4'ha, 4'd0), 3, "alu not");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_AND, 4'hc, 4'ha), 3, "alu and");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_OR, 4'h9, 4'h4), 3, "alu or");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_XOR, 4'hf, 4'h5), 3, "alu xor");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_LESS, 4'hd, 4'h2), 3, "alu -3<2");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_LESS, 4'h5, 4'hf), 3, "alu 5<-1");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_EQUAL, 4'h6, 4'h6), 3, "alu 6==6");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_EQUAL, 4'h6, 4'h7), 3, "alu 6==7");
        for (int i = 0; i < 8; i++) begin
            add_row(lab_pkg::EXP_ALU, alu_switches(3'(i), 4'($urandom), 4'($urandom)), 2,
                    $sformatf("alu random op %0d", i));
        end
        for (int n = 0; n < 8; n++) begin
            din = 8'($urandom);
            add_row(lab_pkg::EXP_SHIFT, shift_switches(din, 3'(n), 1'b1, 1'b0), 2,
                    $sformatf("shift left %0d", n));
            din = 8'($urandom) | 8'h80; // Sign bit set so the zero fill shows.
            add_row(lab_pkg::EXP_SHIFT, shift_switches(din, 3'(n), 1'b0, 1'b0), 2,
                    $sformatf("shift right %0d", n));
            din = 8'($urandom) | 8'h80; // Sign bit set so the fill shows.
            add_row(lab_pkg::EXP_SHIFT, shift_switches(din, 3'(n), 1'b0, 1'b1), 2,
                    $sformatf("shift arith %0d", n));
        end
        for (int i = 0; i < 8; i++) begin
            add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h01 << i, 1'b1), 2,
                    $sformatf("encode bit %0d", i));
        end
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h5a, 1'b1), 2, "encode 5a");
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'hff, 1'b1), 2, "encode ff");
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h03, 1'b1), 2, "encode 03");
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h00, 1'b1), 2, "encode zero");
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h80, 1'b0), 2, "encode disabled");
        add_row(lab_pkg::EXP_RANDOM, 16'h0000, 5, "random resumed");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_XOR, 4'h3, 4'h6), 3, "alu between");
        add_row(lab_pkg::EXP_RANDOM, 16'h0000, 6, "random keeps state");
        // One edge per experiment.
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_ADD, 4'd9, 4'd4), 1, "fast alu");
        add_row(lab_pkg::EXP_SHIFT, shift_switches(8'hb6, 3'd3, 1'b0, 1'b1), 1, "fast shift");
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h24, 1'b1), 1, "fast encode");
        add_row(lab_pkg::EXP_RANDOM, 16'h0000, 1, "fast random");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_SUB, 4'd2, 4'd9), 1, "fast alu sub");
        add_row(lab_pkg::EXP_SHIFT, shift_switches(8'h3c, 3'd2, 1'b1, 1'b0), 1, "fast shift l");
        add_row(lab_pkg::EXP_RANDOM, 16'h0000, 1, "fast random 2");
        add_row(lab_pkg::EXP_ENCODE, encoder_switches(8'h11, 1'b0), 1, "fast encode off");
        add_row(lab_pkg::EXP_ALU, alu_switches(lab_pkg::ALU_AND, 4'he, 4'h7), 3, "final alu");
    endtask

    initial begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = RESET_CYCLES * PERIOD_NS;
        foreach (tab_hold[i]) begin
            limit_ns += (tab_hold[i] + 4) * PERIOD_NS;
        end
        #(limit_ns);
        $display("Timeout: the vector table did not finish within %0d ns.", limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int cycles;
        btn          = 1'b0;
        rst          = 1'b1;
        sw           = '0;
        exp_sel      = '0;
        table_ready  = 1'b0;
        row_errors   = 0;
        total_errors = 0;
        rows_passed  = 0;
        rows_failed  = 0;
        void'($urandom(32'hcc342d90));
        build_table();
        table_ready  = 1'b1;
        cap_sw       = '0;
        cap_sel      = lab_pkg::EXP_ALU;
        model_lfsr   = lab_pkg::LFSR_SEED;
        exp_ledr     = '0;
        exp_seg0     = lab_pkg::SEG_BLANK;
        exp_seg1     = lab_pkg::SEG_BLANK;

        repeat (RESET_CYCLES) @(posedge btn);
        #1;
        rst = 1'b0;
        check_outputs("reset");
        finish_row("reset");

        for (int r = 0; r < tab_sw.size(); r++) begin
            row_errors = 0;
            sw         = tab_sw[r];
            exp_sel    = tab_sel[r];
            cycles     = tab_hold[r];
            if (r == tab_sw.size() - 1) begin
                cycles += 2; // Two more edges flush the last result.
            end
            repeat (cycles) begin
                @(posedge btn);
                #1;
                model_step();
                check_outputs(tab_name[r]);
            end
            finish_row(tab_name[r]);
        end

        $display("rows passed %0d, rows failed %0d, mismatches %0d",
                 rows_passed, rows_failed, total_errors);
        if (rows_failed == 0 && total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/lab_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_board_top (
    input  wire  [0:0]    btn,
    input  wire           rst,
    input  wire  [15:0]   sw,
    input  wire  [1:0]    exp_sel,
    output logic [15:0]   ledr,
    output lab_pkg::seg_t seg0,
    output lab_pkg::seg_t seg1
);

    lab_pkg::exp_sel_e mode;
    lab_pkg::alu_op_e  alu_op;
    logic [3:0]        arg_a;
    logic [3:0]        arg_b;
    logic [7:0]        shift_din;
    logic [2:0]        shamt;
    logic              shift_left;
    logic              shift_arith;
    logic [7:0]        enc_src;
    logic              enc_en;

    logic [3:0]        result;
    logic              zero;
    logic              ovfl;
    logic              carry;
    logic [7:0]        shift_dout;
    logic [2:0]        enc_index;
    logic              enc_any;
    logic [7:0]        rand_value;

    switch_capture i_switch_capture (
        .btn         (btn[0]),
        .rst         (rst),
        .sw          (sw),
        .exp_sel     (exp_sel),
        .mode        (mode),
        .arg_a       (arg_a),
        .arg_b       (arg_b),
        .alu_op      (alu_op),
        .shift_din   (shift_din),
        .shamt       (shamt),
        .shift_left  (shift_left),
        .shift_arith (shift_arith),
        .enc_src     (enc_src),
        .enc_en      (enc_en)
    );

    alu4 i_alu4 (
        .arg_a  (arg_a),
        .arg_b  (arg_b),
        .alu_op (alu_op),
        .result (result),
        .zero   (zero),
        .ovfl   (ovfl),
        .carry  (carry)
    );

    barrel_shifter i_barrel_shifter (
        .shift_din   (shift_din),
        .shamt       (shamt),
        .shift_left  (shift_left),
        .shift_arith (shift_arith),
        .shift_dout  (shift_dout)
    );

    prio_encoder i_prio_encoder (
        .enc_src   (enc_src),
        .enc_en    (enc_en),
        .enc_index (enc_index),
        .enc_any   (enc_any)
    );

    lfsr8 i_lfsr8 (
        .btn        (btn[0]),
        .rst        (rst),
        .mode       (mode),
        .rand_value (rand_value)
    );

    display_driver i_display_driver (
        .btn        (btn[0]),
        .rst        (rst),
        .mode       (mode),
        .result     (result),
        .zero       (zero),
        .ovfl       (ovfl),
        .carry      (carry),
        .shift_dout (shift_dout),
        .enc_index  (enc_index),
        .enc_any    (enc_any),
        .rand_value (rand_value),
        .ledr       (ledr),
        .seg0       (seg0),
        .seg1       (seg1)
    );

endmodule

`default_nettype wire

// ==== source/display_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_driver (
    input  wire                    btn,
    input  wire                    rst,
    input  wire lab_pkg::exp_sel_e mode,
    input  wire  [3:0]             result,
    input  wire                    zero,
    input  wire                    ovfl,
    input  wire                    carry,
    input  wire  [7:0]             shift_dout,
    input  wire  [2:0]             enc_index,
    input  wire                    enc_any,
    input  wire  [7:0]             rand_value,
    output logic [15:0]            ledr,
    output lab_pkg::seg_t          seg0,
    output lab_pkg::seg_t          seg1
);

    logic [15:0]   ledr_d;
    lab_pkg::seg_t seg0_d;
    lab_pkg::seg_t seg1_d;

    always_comb begin
        ledr_d = '0;
        seg0_d = lab_pkg::SEG_BLANK;
        seg1_d = lab_pkg::SEG_BLANK;
        case (mode)
            lab_pkg::EXP_ALU: begin
                ledr_d[6:0] = {carry, ovfl, zero, result};
                seg0_d      = lab_pkg::SEG_HEX[result];
                // Sign digit for negative results.
                seg1_d      = result[3] ? lab_pkg::SEG_MINUS : lab_pkg::SEG_BLANK;
            end
            lab_pkg::EXP_SHIFT: begin
                ledr_d[7:0] = shift_dout;
                seg0_d      = lab_pkg::SEG_HEX[shift_dout[3:0]];
                seg1_d      = lab_pkg::SEG_HEX[shift_dout[7:4]];
            end
            lab_pkg::EXP_ENCODE: begin
                ledr_d[2:0] = enc_index;
                ledr_d[4]   = enc_any;
                if (enc_any) begin
                    seg0_d = lab_pkg::SEG_HEX[{1'b0, enc_index}];
                end
            end
            lab_pkg::EXP_RANDOM: begin
                ledr_d[7:0] = rand_value;
                seg0_d      = lab_pkg::SEG_HEX[rand_value[3:0]];
                seg1_d      = lab_pkg::SEG_HEX[rand_value[7:4]];
            end
            default: begin
                ledr_d = '0;
            end
        endcase
    end

    // Outputs change only on the button edge.
    always_ff @(posedge btn) begin
        if (rst) begin
            ledr <= '0;
            seg0 <= lab_pkg::SEG_BLANK;
            seg1 <= lab_pkg::SEG_BLANK;
        end else begin
            ledr <= ledr_d;
            seg0 <= seg0_d;
            seg1 <= seg1_d;
        end
    end

endmodule

`default_nettype wire

// ==== source/lfsr8.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr8 (
    input  wire                    btn,
    input  wire                    rst,
    input  wire lab_pkg::exp_sel_e mode,
    output logic [7:0]             rand_value
);

    logic feedback;

    assign feedback = rand_value[4] ^ rand_value[3] ^ rand_value[2] ^ rand_value[0];

    always_ff @(posedge btn) begin
        if (rst) begin
            rand_value <= lab_pkg::LFSR_SEED;
        end else if (rand_value == 8'd0) begin
            rand_value <= lab_pkg::LFSR_SEED; // Escape the lock-up state.
        end else if (mode == lab_pkg::EXP_RANDOM) begin
            rand_value <= {feedback, rand_value[7:1]};
        end
    end

endmodule

`default_nettype wire

// ==== source/prio_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prio_encoder (
    input  wire  [7:0] enc_src,
    input  wire        enc_en,
    output logic [2:0] enc_index,
    output logic       enc_any
);

    assign enc_any = enc_en & (|enc_src);

    // Scan upward so the highest set bit wins.
    always_comb begin
        enc_index = 3'd0;
        if (enc_any) begin
            for (int i = 0; i < 8; i++) begin
                if (enc_src[i]) begin
                    enc_index = i[2:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
    input  wire  [7:0] shift_din,
    input  wire  [2:0] shamt,
    input  wire        shift_left,
    input  wire        shift_arith,
    output logic [7:0] shift_dout
);

    logic       fill;
    logic [7:0] stage1;
    logic [7:0] stage2;

    // Sign fill only on arithmetic right shifts.
    assign fill = shift_arith & shift_din[7] & ~shift_left;

    // Shift by one.
    assign stage1 = !shamt[0]  ? shift_din :
                    shift_left ? {shift_din[6:0], 1'b0} :
                                 {fill, shift_din[7:1]};

    // Shift by two.
    assign stage2 = !shamt[1]  ? stage1 :
                    shift_left ? {stage1[5:0], 2'b00} :
                                 {{2{fill}}, stage1[7:2]};

    // Shift by four.
    assign shift_dout = !shamt[2]  ? stage2 :
                        shift_left ? {stage2[3:0], 4'b0000} :
                                     {{4{fill}}, stage2[7:4]};

endmodule

`default_nettype wire

// ==== source/alu4.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu4 (
    input  wire  [3:0]             arg_a,
    input  wire  [3:0]             arg_b,
    input  wire lab_pkg::alu_op_e  alu_op,
    output logic [3:0]             result,
    output logic                   zero,
    output logic                   ovfl,
    output logic                   carry
);

    logic       sub;
    logic [3:0] b_eff;
    logic [4:0] sum;

    // Subtract is a plus inverted b plus one.
    assign sub   = (alu_op == lab_pkg::ALU_SUB);
    assign b_eff = sub ? ~arg_b : arg_b;
    assign sum   = {1'b0, arg_a} + {1'b0, b_eff} + {4'd0, sub};

    always_comb begin
        result = '0;
        ovfl   = 1'b0;
        carry  = 1'b0;
        case (alu_op)
            lab_pkg::ALU_ADD,
            lab_pkg::ALU_SUB: begin
                result = sum[3:0];
                carry  = sum[4];
                // Same operand signs, different result sign.
                ovfl   = (arg_a[3] == b_eff[3]) && (sum[3] != arg_a[3]);
            end
            lab_pkg::ALU_NOT: begin
                result = ~arg_a;
            end
            lab_pkg::ALU_AND: begin
                result = arg_a & arg_b;
            end
            lab_pkg::ALU_OR: begin
                result = arg_a | arg_b;
            end
            lab_pkg::ALU_XOR: begin
                result = arg_a ^ arg_b;
            end
            lab_pkg::ALU_LESS: begin
                result = {3'd0, $signed(arg_a) < $signed(arg_b)};
            end
            lab_pkg::ALU_EQUAL: begin
                result = {3'd0, arg_a == arg_b};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == 4'd0);

endmodule

`default_nettype wire

// ==== source/switch_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_capture (
    input  wire                    btn,
    input  wire                    rst,
    input  wire  [15:0]            sw,
    input  wire  [1:0]             exp_sel,
    output lab_pkg::exp_sel_e      mode,
    output logic [3:0]             arg_a,
    output logic [3:0]             arg_b,
    output lab_pkg::alu_op_e       alu_op,
    output logic [7:0]             shift_din,
    output logic [2:0]             shamt,
    output logic                   shift_left,
    output logic                   shift_arith,
    output logic [7:0]             enc_src,
    output logic                   enc_en
);

    logic [15:0] sw_q;

    // Switches are sampled once per button press.
    always_ff @(posedge btn) begin
        if (rst) begin
            sw_q <= '0;
            mode <= lab_pkg::EXP_ALU;
        end else begin
            sw_q <= sw;
            mode <= lab_pkg::exp_sel_e'(exp_sel);
        end
    end

    // ALU fields.
    assign arg_a  = sw_q[3:0];
    assign arg_b  = sw_q[7:4];
    assign alu_op = lab_pkg::alu_op_e'(sw_q[10:8]);

    // Shifter fields.
    assign shift_din   = sw_q[7:0];
    assign shamt       = sw_q[15:13];
    assign shift_left  = sw_q[12];
    assign shift_arith = sw_q[11];

    // Encoder fields.
    assign enc_src = sw_q[7:0];
    assign enc_en  = sw_q[8];

endmodule

`default_nettype wire

// ==== source/lab_pkg.sv ====
`default_nettype none

package lab_pkg;

    // Experiment select as set on the board select switches.
    typedef enum logic [1:0] {
        EXP_ALU    = 2'd0,
        EXP_SHIFT  = 2'd1,
        EXP_ENCODE = 2'd2,
        EXP_RANDOM = 2'd3
    } exp_sel_e;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_NOT   = 3'd2,
        ALU_AND   = 3'd3,
        ALU_OR    = 3'd4,
        ALU_XOR   = 3'd5,
        ALU_LESS  = 3'd6, // Signed compare.
        ALU_EQUAL = 3'd7
    } alu_op_e;

    // Active low with dp in bit 7 and segments g..a in bits 6:0.
    typedef logic [7:0] seg_t;

    localparam seg_t SEG_HEX [0:15] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0,
        8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    localparam seg_t SEG_BLANK = 8'hff;
    localparam seg_t SEG_MINUS = 8'hbf; // Segment g only.

    localparam logic [7:0] LFSR_SEED = 8'h01;

endpackage

`default_nettype wire
